// File: common/video_pkg.sv
package video_pkg;

	typedef logic [10:0] coord_t;   // Pixel/line count or compare point
	typedef logic [3:0]  sw_code_t; // Raw or debounced switch code
	typedef logic [7:0]  clk_div_t; // Synthesizer M or D, minus one

	// Switch codes of the supported modes
	typedef enum logic [3:0] {
		MODE_VGA      = 4'b0000,
		MODE_SVGA     = 4'b0001,
		MODE_HDTV720P = 4'b0010,
		MODE_XGA      = 4'b0011,
		MODE_SXGA     = 4'b1000,
		MODE_CAMERA   = 4'b1001
	} mode_t;

	typedef struct packed {
		clk_div_t m; // Multiplier minus one
		clk_div_t d; // Divider minus one
	} clk_set_t;

	typedef struct packed {
		coord_t hpixels;
		coord_t hfporch;
		coord_t hsync_w;
		coord_t hbporch;
		coord_t vlines;
		coord_t vfporch;
		coord_t vsync_w;
		coord_t vbporch;
	} mode_timing_t;

	// Compare points, all inclusive upper bounds of the previous region
	typedef struct packed {
		coord_t hsblnk;
		coord_t hssync;
		coord_t hesync;
		coord_t heblnk;
		coord_t vsblnk;
		coord_t vssync;
		coord_t vesync;
		coord_t veblnk;
		logic   neg_polarity; // Sync active low
	} tc_t;

	//////////////////////////////////////////////////////////////////////
	// Mode table: active, front porch, sync, back porch
	//////////////////////////////////////////////////////////////////////
	localparam mode_timing_t TIMING_VGA      = '{11'd640, 11'd16, 11'd96, 11'd48,
		11'd480, 11'd11, 11'd2, 11'd31};
	localparam mode_timing_t TIMING_SVGA     = '{11'd800, 11'd40, 11'd128, 11'd88,
		11'd600, 11'd1, 11'd4, 11'd23};
	localparam mode_timing_t TIMING_XGA      = '{11'd1024, 11'd24, 11'd136, 11'd160,
		11'd768, 11'd3, 11'd6, 11'd29};
	localparam mode_timing_t TIMING_HDTV720P = '{11'd1280, 11'd110, 11'd40, 11'd220,
		11'd720, 11'd5, 11'd5, 11'd20};
	localparam mode_timing_t TIMING_SXGA     = '{11'd1280, 11'd48, 11'd112, 11'd248,
		11'd1024, 11'd1, 11'd3, 11'd38};
	localparam mode_timing_t TIMING_CAMERA   = '{11'd1280, 11'd110, 11'd39, 11'd220,
		11'd720, 11'd4, 11'd4, 11'd22};

	// Pixel clock settings, 50 MHz * (M+1) / (D+1)
	localparam clk_set_t CLK_VGA      = '{8'd1, 8'd3};     // 25 MHz
	localparam clk_set_t CLK_SVGA     = '{8'd3, 8'd4};     // 40 MHz
	localparam clk_set_t CLK_XGA      = '{8'd12, 8'd9};    // 65 MHz
	localparam clk_set_t CLK_SXGA     = '{8'd53, 8'd24};   // 108 MHz
	localparam clk_set_t CLK_CAMERA   = '{8'd134, 8'd90};
	localparam clk_set_t CLK_HDTV720P = '{8'd247, 8'd166}; // 74.25 MHz

	function automatic mode_timing_t mode_timing(mode_t mode);
		case (mode)
			MODE_VGA:    return TIMING_VGA;
			MODE_SVGA:   return TIMING_SVGA;
			MODE_XGA:    return TIMING_XGA;
			MODE_SXGA:   return TIMING_SXGA;
			MODE_CAMERA: return TIMING_CAMERA;
			default:     return TIMING_HDTV720P;
		endcase
	endfunction

	// VGA and XGA use negative sync, the rest positive
	function automatic logic mode_neg_polarity(mode_t mode);
		return (mode == MODE_VGA) || (mode == MODE_XGA);
	endfunction

	function automatic clk_set_t mode_clk_set(mode_t mode);
		case (mode)
			MODE_VGA:    return CLK_VGA;
			MODE_SVGA:   return CLK_SVGA;
			MODE_XGA:    return CLK_XGA;
			MODE_SXGA:   return CLK_SXGA;
			MODE_CAMERA: return CLK_CAMERA;
			default:     return CLK_HDTV720P;
		endcase
	endfunction

endpackage

// File: rtl/mode_select.sv
`timescale 1ns/100ps

module mode_select
	import video_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 500000 // Cycles of stable input before accept
) (
	input  logic     clk50m_bufg,
	input  logic     rst,
	input  sw_code_t sw,          // Asynchronous board switches
	output mode_t    mode,
	output clk_set_t clk_set,
	output logic     prog_go,     // Load M/D into synthesizer
	output logic     mode_change  // High in first cycle of new mode
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	sw_code_t         sw_meta;    // First sync stage
	sw_code_t         sw_sync;    // Second sync stage
	sw_code_t         sw_prev;    // Previous sample for compare
	logic [CNT_W-1:0] stable_cnt;
	logic             stable;
	mode_t            new_mode;

	// Undefined codes fall back to 720p
	function automatic mode_t decode_sw(sw_code_t code);
		case (code)
			MODE_VGA, MODE_SVGA, MODE_HDTV720P,
			MODE_XGA, MODE_SXGA, MODE_CAMERA: return mode_t'(code);
			default: return MODE_HDTV720P;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Synchronizer and debouncer
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			sw_meta <= '0;
			sw_sync <= '0;
			sw_prev <= '0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
			sw_prev <= sw_sync;
		end
	end

	assign stable = (stable_cnt == CNT_W'(DEBOUNCE_CYCLES));

	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			stable_cnt <= '0;
		end else if (sw_sync != sw_prev) begin
			stable_cnt <= '0; // Any movement restarts the wait
		end else if (!stable) begin
			stable_cnt <= stable_cnt + CNT_W'(1);
		end
	end

	assign new_mode = decode_sw(sw_prev);

	//////////////////////////////////////////////////////////////////////
	// Mode and clock-setting registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			mode        <= MODE_VGA;
			clk_set     <= CLK_VGA;
			mode_change <= 1'b0;
			prog_go     <= 1'b0;
		end else begin
			mode_change <= 1'b0;
			prog_go     <= mode_change; // One cycle behind the mode update
			if (stable && (new_mode != mode)) begin
				mode        <= new_mode;
				clk_set     <= mode_clk_set(new_mode);
				mode_change <= 1'b1;
			end
		end
	end

endmodule

// File: video_timing/timing_table.sv
`timescale 1ns/100ps

module timing_table
	import video_pkg::*;
(
	input  logic  clk50m_bufg,
	input  logic  rst,
	input  mode_t mode,
	output tc_t   tc // Follows mode by one cycle
);

	// Each point is the last count of the region before it
	function automatic tc_t compare_points(mode_t m);
		mode_timing_t mt;
		tc_t          pts;
		mt = mode_timing(m);
		pts.hsblnk       = mt.hpixels - 11'd1;      // Last active pixel
		pts.hssync       = pts.hsblnk + mt.hfporch; // End of front porch
		pts.hesync       = pts.hssync + mt.hsync_w; // Last sync pixel
		pts.heblnk       = pts.hesync + mt.hbporch; // Last pixel of line
		pts.vsblnk       = mt.vlines - 11'd1;
		pts.vssync       = pts.vsblnk + mt.vfporch;
		pts.vesync       = pts.vssync + mt.vsync_w;
		pts.veblnk       = pts.vesync + mt.vbporch;
		pts.neg_polarity = mode_neg_polarity(m);
		return pts;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Registered lookup, breaks the adder chain from the counters
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			tc <= compare_points(MODE_VGA); // Matches reset mode
		end else begin
			tc <= compare_points(mode);
		end
	end

endmodule

// File: video_timing/timing_gen.sv
`timescale 1ns/100ps

module timing_gen
	import video_pkg::*;
(
	input  logic   clk50m_bufg,
	input  logic   rst,
	input  logic   restart, // Mode change, clears counters and pipe
	input  tc_t    tc,
	output logic   hsync,
	output logic   vsync,
	output logic   de,
	output coord_t hcount,
	output coord_t vcount
);

	// One stage of the output delay line
	typedef struct packed {
		logic   hsync;
		logic   vsync;
		logic   de;
		coord_t hcount;
		coord_t vcount;
	} vid_t;

	// VGA sync idles high
	localparam vid_t VGA_IDLE = '{1'b1, 1'b1, 1'b0, 11'd0, 11'd0};

	coord_t h_cnt;
	coord_t v_cnt;
	logic   h_wrap;    // Last pixel of line
	logic   h_blnk;
	logic   v_blnk;
	logic   h_sync_on; // Sync region, before polarity
	logic   v_sync_on;
	vid_t   pipe_in;
	vid_t   pipe_idle;
	vid_t   pipe_q1;
	vid_t   pipe_q2;

	//////////////////////////////////////////////////////////////////////
	// Horizontal and vertical counters
	//////////////////////////////////////////////////////////////////////
	assign h_wrap = (h_cnt == tc.heblnk);

	always_ff @(posedge clk50m_bufg) begin
		if (rst || restart) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_wrap) begin
			h_cnt <= '0;
			if (v_cnt == tc.veblnk) begin
				v_cnt <= '0; // End of frame
			end else begin
				v_cnt <= v_cnt + 11'd1;
			end
		end else begin
			h_cnt <= h_cnt + 11'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Blanking, sync and enable decode
	//////////////////////////////////////////////////////////////////////
	assign h_blnk    = (h_cnt > tc.hsblnk);
	assign v_blnk    = (v_cnt > tc.vsblnk);
	assign h_sync_on = (h_cnt > tc.hssync) && (h_cnt <= tc.hesync);
	assign v_sync_on = (v_cnt > tc.vssync) && (v_cnt <= tc.vesync);

	always_comb begin
		pipe_in.hsync  = h_sync_on ^ tc.neg_polarity; // Low active when negative
		pipe_in.vsync  = v_sync_on ^ tc.neg_polarity;
		pipe_in.de     = !h_blnk && !v_blnk;
		pipe_in.hcount = h_cnt;
		pipe_in.vcount = v_cnt;
	end

	// Inactive sync at the current polarity
	always_comb begin
		pipe_idle        = '0;
		pipe_idle.hsync  = tc.neg_polarity;
		pipe_idle.vsync  = tc.neg_polarity;
	end

	//////////////////////////////////////////////////////////////////////
	// Two-stage output delay, counts travel with sync and de
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			pipe_q1 <= VGA_IDLE;
			pipe_q2 <= VGA_IDLE;
		end else if (restart) begin
			pipe_q1 <= pipe_idle;
			pipe_q2 <= pipe_idle;
		end else begin
			pipe_q1 <= pipe_in;
			pipe_q2 <= pipe_q1;
		end
	end

	assign hsync  = pipe_q2.hsync;
	assign vsync  = pipe_q2.vsync;
	assign de     = pipe_q2.de;
	assign hcount = pipe_q2.hcount;
	assign vcount = pipe_q2.vcount;

endmodule

// File: rtl/video_top.sv
`timescale 1ns/100ps

module video_top
	import video_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 500000 // About 10 ms at 50 MHz
) (
	input  logic     clk50m_bufg,
	input  logic     rst,
	input  sw_code_t sw,      // Mode switches
	output logic     hsync,
	output logic     vsync,
	output logic     de,
	output coord_t   hcount,
	output coord_t   vcount,
	output clk_set_t clk_set, // Pixel clock M/D
	output logic     prog_go,
	output mode_t    mode
);

	logic mode_change; // Restart for the raster
	tc_t  tc;

	mode_select #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) mode_select_inst (
		.clk50m_bufg(clk50m_bufg),
		.rst        (rst),
		.sw         (sw),
		.mode       (mode),
		.clk_set    (clk_set),
		.prog_go    (prog_go),
		.mode_change(mode_change)
	);

	timing_table timing_table_inst (
		.clk50m_bufg(clk50m_bufg),
		.rst        (rst),
		.mode       (mode),
		.tc         (tc)
	);

	timing_gen timing_gen_inst (
		.clk50m_bufg(clk50m_bufg),
		.rst        (rst),
		.restart    (mode_change),
		.tc         (tc),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.hcount     (hcount),
		.vcount     (vcount)
	);

endmodule

// File: verification/video_ref.svh
`ifndef VIDEO_REF_SVH
`define VIDEO_REF_SVH

// Expected numbers of one mode
typedef struct packed {
	int h_total;  // Cycles per line
	int h_active; // Cycles of de per line
	int h_sync;   // Cycles of hsync pulse
	int v_total;  // Lines per frame
	int v_active; // Lines with de
	int v_sync;   // Lines of vsync pulse
	bit neg_pol;  // Sync active low
	int clk_m;    // M minus one
	int clk_d;    // D minus one
} mode_ref_t;

// Switch code to mode code, undefined codes land on 720p
function automatic logic [3:0] expected_code(logic [3:0] sw_code);
	case (sw_code)
		4'b0000, 4'b0001, 4'b0010, 4'b0011, 4'b1000, 4'b1001: return sw_code;
		default: return 4'b0010;
	endcase
endfunction

// Totals are active + front porch + sync + back porch
function automatic mode_ref_t expected_mode(logic [3:0] sw_code);
	mode_ref_t r;
	case (expected_code(sw_code))
		4'b0000: r = '{800, 640, 96, 524, 480, 2, 1'b1, 1, 3};         // VGA
		4'b0001: r = '{1056, 800, 128, 628, 600, 4, 1'b0, 3, 4};       // SVGA
		4'b0011: r = '{1344, 1024, 136, 806, 768, 6, 1'b1, 12, 9};     // XGA
		4'b1000: r = '{1688, 1280, 112, 1066, 1024, 3, 1'b0, 53, 24};  // SXGA
		4'b1001: r = '{1649, 1280, 39, 750, 720, 4, 1'b0, 134, 90};    // Camera
		default: r = '{1650, 1280, 40, 750, 720, 5, 1'b0, 247, 166};   // 720p
	endcase
	return r;
endfunction

`endif

// File: verification/video_tb.sv
`timescale 1ns/100ps

module video_tb
	import video_pkg::*;
();

	`include "video_ref.svh"

	localparam int DEBOUNCE  = 16; // Short debounce for simulation
	localparam int SEL_HSYNC = 0;
	localparam int SEL_VSYNC = 1;
	localparam int SEL_DE    = 2;

	logic        clk50m_bufg;
	logic        rst;
	sw_code_t    sw;
	logic        hsync;
	logic        vsync;
	logic        de;
	coord_t      hcount;
	coord_t      vcount;
	clk_set_t    clk_set;
	logic        prog_go;
	mode_t       mode;
	logic [31:0] lfsr;        // Glitch length and code source
	int          error_count;
	int          check_count;
	int          test_errors; // Errors before current test
	int          tests_passed;
	int          tests_failed;

	video_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE)
	) video_top_inst (
		.clk50m_bufg(clk50m_bufg),
		.rst        (rst),
		.sw         (sw),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.hcount     (hcount),
		.vcount     (vcount),
		.clk_set    (clk_set),
		.prog_go    (prog_go),
		.mode       (mode)
	);

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz
	end

	//////////////////////////////////////////////////////////////////////
	// Checks and measurement
	//////////////////////////////////////////////////////////////////////
	task automatic check_value(input string name, input int got, input int expected);
		check_count++;
		assert (got == expected) else begin
			$display("FAILED at %0d ns: %s is %0d, expected %0d", $time, name, got, expected);
			error_count++;
		end
	endtask

	function automatic logic probe(int sel);
		case (sel)
			SEL_HSYNC: return hsync;
			SEL_VSYNC: return vsync;
			default:   return de;
		endcase
	endfunction

	// Falling edges until the signal sits at level
	task automatic wait_level(input int sel, input string name, input logic level,
		input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk50m_bufg);
			cycles++;
		end while (probe(sel) != level && cycles < limit);
		assert (probe(sel) == level) else begin
			$display("Timeout: %s did not reach %0b within %0d cycles", name, level, limit);
			error_count++;
		end
	endtask

	// Width of the next pulse at level, and distance to the pulse after it
	task automatic measure_pulse(input int sel, input string name, input logic level,
		input int limit, output int width, output int period);
		int skip;
		int rest;
		wait_level(sel, name, !level, limit, skip);
		wait_level(sel, name, level, limit, skip); // Leading edge
		wait_level(sel, name, !level, limit, width);
		wait_level(sel, name, level, limit, rest);
		period = width + rest;
	endtask

	task automatic check_line_timing(input sw_code_t code);
		mode_ref_t r;
		int        limit;
		int        width;
		int        period;
		r     = expected_mode(code);
		limit = r.h_total * (r.v_total + 1); // de may sit in vertical blanking
		measure_pulse(SEL_DE, "de", 1'b1, limit, width, period);
		check_value("de run", width, r.h_active);
		measure_pulse(SEL_HSYNC, "hsync", !r.neg_pol, limit, width, period);
		check_value("hsync pulse", width, r.h_sync);
		check_value("hsync period", period, r.h_total);
	endtask

	// Lines counted by hsync leading edges between two vsync leading edges
	task automatic check_frame(input sw_code_t code);
		mode_ref_t r;
		logic      act;
		logic      h_prev;
		logic      v_prev;
		logic      d_prev;
		logic      done;
		int        limit;
		int        cycles;
		int        lines;
		int        sync_lines;
		int        de_lines;
		r     = expected_mode(code);
		act   = !r.neg_pol;
		limit = 2 * r.h_total * r.v_total;
		wait_level(SEL_VSYNC, "vsync", !act, limit, cycles);
		wait_level(SEL_VSYNC, "vsync", act, limit, cycles); // Frame start
		lines      = 0;
		sync_lines = 0;
		de_lines   = 0;
		cycles     = 0;
		h_prev     = hsync;
		v_prev     = vsync;
		d_prev     = de;
		do begin
			@(negedge clk50m_bufg);
			cycles++;
			if (hsync == act && h_prev != act) begin
				lines++;
				if (vsync == act) begin
					sync_lines++; // Line inside vsync pulse
				end
			end
			if (de && !d_prev) begin
				de_lines++;
			end
			done   = (vsync == act) && (v_prev != act);
			h_prev = hsync;
			v_prev = vsync;
			d_prev = de;
		end while (!done && cycles < limit);
		assert (done) else begin
			$display("Timeout: no second vsync edge within %0d cycles", limit);
			error_count++;
		end
		check_value("frame lines", lines, r.v_total);
		check_value("vsync lines", sync_lines, r.v_sync);
		check_value("de lines", de_lines, r.v_active);
	endtask

	task automatic check_mode(input sw_code_t code);
		mode_ref_t r;
		r = expected_mode(code);
		check_value("mode", int'(mode), int'(expected_code(code)));
		check_value("clk_set.m", int'(clk_set.m), r.clk_m);
		check_value("clk_set.d", int'(clk_set.d), r.clk_d);
	endtask

	// Counts cycles where mode, clk_set or prog_go leave the code's values
	task automatic hold_steady(input int n, input sw_code_t code, inout int bad);
		mode_ref_t r;
		r = expected_mode(code);
		repeat (n) begin
			@(negedge clk50m_bufg);
			if (int'(mode) != int'(expected_code(code)) || int'(clk_set.m) != r.clk_m
				|| int'(clk_set.d) != r.clk_d || prog_go) begin
				bad++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		repeat (n) begin
			lfsr  = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	// Called on a falling edge, returns on the first cycle of the new mode
	task automatic switch_mode(input sw_code_t code);
		mode_t old;
		int    cycles;
		old    = mode;
		sw     = code;
		cycles = 0;
		do begin
			@(negedge clk50m_bufg);
			cycles++;
		end while (mode == old && cycles < 4 * DEBOUNCE);
		assert (mode != old) else begin
			$display("Timeout: mode did not change after switch code %b", code);
			error_count++;
		end
	endtask

	task automatic end_test(input string name);
		if (error_count == test_errors) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, error_count - test_errors);
		end
		test_errors = error_count;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		int       bad;
		int       len;
		int       gap;
		int       bits;
		sw_code_t glitch;
		rst          = 1'b1;
		sw           = 4'b0000;
		lfsr         = 32'h1bf0cbea;
		error_count  = 0;
		check_count  = 0;
		test_errors  = 0;
		tests_passed = 0;
		tests_failed = 0;

		repeat (8) @(negedge clk50m_bufg); // Eight cycles in reset
		check_mode(4'b0000);
		check_value("prog_go", int'(prog_go), 0);
		check_value("de", int'(de), 0);
		check_value("hsync", int'(hsync), 1); // VGA idle level
		check_value("vsync", int'(vsync), 1);
		rst = 1'b0;
		@(negedge clk50m_bufg);
		check_value("hsync", int'(hsync), 1);
		check_value("vsync", int'(vsync), 1);
		check_value("de", int'(de), 0);
		end_test("reset state");

		check_line_timing(4'b0000);
		end_test("VGA lines");

		check_frame(4'b0000);
		end_test("VGA frame");

		switch_mode(4'b0001);
		check_mode(4'b0001);
		check_value("prog_go", int'(prog_go), 0); // Cycle of mode update
		@(negedge clk50m_bufg);
		check_value("prog_go", int'(prog_go), 1);
		@(negedge clk50m_bufg);
		check_value("prog_go", int'(prog_go), 0);
		check_value("hcount", int'(hcount), 0);
		repeat (2) @(negedge clk50m_bufg);
		check_value("hcount", int'(hcount), 1); // Count 1 after the delay pipe
		check_value("vcount", int'(vcount), 0);
		check_line_timing(4'b0001);
		end_test("switch to SVGA");

		bad = 0;
		repeat (8) begin
			random_bits(4, bits);
			len = (bits == 0) ? 1 : bits; // Always under the debounce time
			random_bits(4, bits);
			glitch = bits[3:0];
			if (glitch == 4'b0001) begin
				glitch = glitch ^ 4'b0100;
			end
			random_bits(3, gap);
			sw = glitch;
			hold_steady(len, 4'b0001, bad);
			sw = 4'b0001;
			hold_steady(gap + 2, 4'b0001, bad);
		end
		hold_steady(2 * DEBOUNCE, 4'b0001, bad);
		check_value("cycles with mode, clk_set or prog_go moved", bad, 0);
		check_mode(4'b0001);
		end_test("glitch rejection");

		switch_mode(4'b0101); // Undefined code
		check_mode(4'b0101);
		check_line_timing(4'b0101);
		switch_mode(4'b0011);
		check_mode(4'b0011);
		check_line_timing(4'b0011);
		end_test("undefined code and XGA");

		$display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
			tests_passed, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verification
common/video_pkg.sv
rtl/mode_select.sv
video_timing/timing_table.sv
video_timing/timing_gen.sv
rtl/video_top.sv
verification/video_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the video timing testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module video_tb -o video_tb_sim
sim_out=$(./obj_dir/video_tb_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "No errors"; then
	exit 0
fi
exit 1
